// File: rtl/colmix_pkg.sv
/*
  shared types for the colour mixer, the CPU bus and the pixel pipeline
  palette words keep the arcade layout: channel LSBs sit in bits 14:12
  pixel pipeline depth is fixed at BLANK_DLY strobes
*/
package colmix_pkg;

    // palette index: {sprite flag, palette[5:0], colour index[3:0]}
    typedef logic [10:0] pal_addr_t;
    // palette entry: bit 15 shadow immune, 14:12 channel LSBs, 11:0 channel MSBs
    typedef logic [15:0] pal_word_t;
    // {red, green, blue}, 5 bits each
    typedef logic [14:0] rgb15_t;
    // one colour channel
    typedef logic [4:0]  chan_t;

    localparam int PAL_DEPTH = 2048;
    // sprite palette that means "darken whatever is below"
    localparam logic [5:0] SHADOW_PAL = 6'h3f;
    // pixel strobes from input to rgb
    localparam int BLANK_DLY = 3;

    typedef struct packed {
        logic [6:0]  char_pxl;
        logic [10:0] scr1_pxl;
        logic [10:0] scr2_pxl;
        logic [11:0] obj_pxl;
    } layer_pixels_t;

    typedef struct packed {
        logic      shadow;
        pal_addr_t pal_addr;
    } mix_sel_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        // 0 palette, 1 control register
        logic        sel;
        logic [10:0] addr;
        logic [15:0] data;
        logic [1:0]  be;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] data;
    } cpu_rsp_t;

    // lives in data bits 4:0 of the control register
    typedef struct packed {
        logic       video_en;
        logic [3:0] gfx_en;
    } ctrl_t;

    localparam ctrl_t CTRL_RESET = '{video_en: 1'b1, gfx_en: 4'hf};

endpackage

// File: rtl/video_ctrl_regs.sv
/*
  CPU bus decode for the colour mixer
  one request per clock at most, wr and rd never together
  read data is valid for one clock, on the clock after rd
  control register writes take data bits 4:0 and ignore be
*/
`timescale 1ns/1ns

module video_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  colmix_pkg::cpu_req_t  cpu_req,
    output colmix_pkg::cpu_rsp_t  cpu_rsp,
    output logic [1:0]            pal_we,
    output colmix_pkg::pal_addr_t pal_addr,
    output colmix_pkg::pal_word_t pal_wdata,
    input  colmix_pkg::pal_word_t pal_rdata,
    output colmix_pkg::ctrl_t     ctrl
);
    import colmix_pkg::*;

    ctrl_t ctrl_q;
    logic  rsp_valid_q;
    // which target the pending read went to
    logic  rsp_sel_q;
    logic  ctrl_wr;

    // palette byte lanes, be[1] is the upper byte
    assign pal_we    = cpu_req.be & {2{cpu_req.wr & ~cpu_req.sel}};
    assign pal_addr  = cpu_req.addr;
    assign pal_wdata = cpu_req.data;

    assign ctrl_wr = cpu_req.wr & cpu_req.sel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= CTRL_RESET;
        end else if (ctrl_wr) begin
            ctrl_q <= cpu_req.data[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= cpu_req.rd;
        end
    end

    // latched with the read request
    always_ff @(posedge clk) begin
        if (cpu_req.rd) begin
            rsp_sel_q <= cpu_req.sel;
        end
    end

    // palette data arrives from the RAM's registered CPU port
    // ctrl is unchanged between rd and response since wr and rd never coincide
    assign cpu_rsp.valid = rsp_valid_q;
    assign cpu_rsp.data  = rsp_sel_q ? {11'd0, ctrl_q} : pal_rdata;

    assign ctrl = ctrl_q;

    // single command per clock
    a_no_wr_rd: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cpu_req.wr && cpu_req.rd)
    );

endmodule

// File: rtl/layer_prio_mixer.sv
/*
  layer priority mixer, one pixel strobe of latency
  four slots arbitrate the sprite against each tile layer, then the
  first opaque slot wins; slot 3 is the fallback and always shows
  sel is combinational from the slot registers
*/
`timescale 1ns/1ns

module layer_prio_mixer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  colmix_pkg::layer_pixels_t pixels,
    input  logic [3:0]                gfx_en,
    output colmix_pkg::mix_sel_t      sel
);
    import colmix_pkg::*;

    logic [6:0]  char_g;
    logic [10:0] scr1_g;
    logic [10:0] scr2_g;
    logic [11:0] obj_g;
    logic [1:0]  obj_prio;

    mix_sel_t slot0, slot1, slot2, slot3;

    // sprite against one tile
    // pal_addr[10] marks the sprite, shadow keeps the tile colour
    function automatic mix_sel_t tile_or_obj(
        input logic [9:0] obj,
        input logic [9:0] tile,
        input logic       tile_prio,
        input logic       obj_ok
    );
        mix_sel_t r;
        logic     obj_wins;
        obj_wins = (obj[3:0] != 4'd0) && obj_ok && (!tile_prio || tile[2:0] == 3'd0);
        if (obj_wins && obj[9:4] == SHADOW_PAL) begin
            // shadow sprite, tile shows through darkened
            r.shadow   = 1'b1;
            r.pal_addr = {1'b0, tile};
        end else if (obj_wins) begin
            r.shadow   = 1'b0;
            r.pal_addr = {1'b1, obj};
        end else begin
            r.shadow   = 1'b0;
            r.pal_addr = {1'b0, tile};
        end
        return r;
    endfunction

    // sprites test all four index bits, tiles only the low three
    function automatic logic opaque(input mix_sel_t s);
        logic o;
        if (s.pal_addr[10]) begin
            o = s.pal_addr[3:0] != 4'd0;
        end else begin
            o = s.pal_addr[2:0] != 3'd0;
        end
        return o;
    endfunction

    // disabled layer keeps its palette but loses its index
    always_comb begin
        char_g = pixels.char_pxl;
        scr1_g = pixels.scr1_pxl;
        scr2_g = pixels.scr2_pxl;
        obj_g  = pixels.obj_pxl;
        if (!gfx_en[0]) char_g[3:0] = 4'd0;
        if (!gfx_en[1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[3]) obj_g[3:0]  = 4'd0;
    end

    assign obj_prio = obj_g[11:10];

    // stage 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot0 <= '0;
            slot1 <= '0;
            slot2 <= '0;
            slot3 <= '0;
        end else if (pxl_cen) begin
            // char layer, sprite only at top priority
            slot0 <= tile_or_obj(obj_g[9:0], {4'd0, char_g[5:0]}, char_g[6],
                                 obj_prio == 2'd3);
            slot1 <= tile_or_obj(obj_g[9:0], scr1_g[9:0], scr1_g[10],
                                 obj_prio >= 2'd2);
            slot2 <= tile_or_obj(obj_g[9:0], scr2_g[9:0], scr2_g[10],
                                 obj_prio >= 2'd1);
            // backdrop: scroll 2 palette with index forced to colour 0
            slot3 <= tile_or_obj(obj_g[9:0], {scr2_g[9:3], 3'd0}, 1'b0, 1'b1);
        end
    end

    // final pick, slot 0 is the front
    always_comb begin
        if (opaque(slot0)) begin
            sel = slot0;
        end else if (opaque(slot1)) begin
            sel = slot1;
        end else if (opaque(slot2)) begin
            sel = slot2;
        end else begin
            sel = slot3;
        end
    end

endmodule

// File: rtl/palette_ram.sv
/*
  palette RAM, PAL_DEPTH words of 16 bits, no reset
  contents are undefined until the CPU writes them
  CPU port: byte writes, read registered every clock, old data on a write
  pixel port: read only, registered on pxl_cen
*/
`timescale 1ns/1ns

module palette_ram (
    input  logic                  clk,
    input  logic                  pxl_cen,
    input  logic [1:0]            we,
    input  colmix_pkg::pal_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t wdata,
    output colmix_pkg::pal_word_t cpu_q,
    input  colmix_pkg::pal_addr_t pix_addr,
    output colmix_pkg::pal_word_t pix_q
);
    import colmix_pkg::*;

    pal_word_t mem [PAL_DEPTH];

    // CPU side, we[0] low byte, we[1] high byte
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[cpu_addr][7:0] <= wdata[7:0];
        end
        if (we[1]) begin
            mem[cpu_addr][15:8] <= wdata[15:8];
        end
    end

    always_ff @(posedge clk) begin
        cpu_q <= mem[cpu_addr];
    end

    // stage 2, pixel lookup
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pix_q <= mem[pix_addr];
        end
    end

endmodule

// File: rtl/shade_blank.sv
/*
  final pixel stage: palette unpack, shadow dimming, video enable and blanking
  shadow arrives one strobe ahead of pal and is realigned here
  lhbl and lvbl are active low and delayed BLANK_DLY strobes to match rgb
  video_en acts at once, it is not pipelined
*/
`timescale 1ns/1ns

module shade_blank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  shadow,
    input  colmix_pkg::pal_word_t pal,
    input  logic                  video_en,
    input  logic                  lhbl,
    input  logic                  lvbl,
    output colmix_pkg::rgb15_t    rgb,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly
);
    import colmix_pkg::*;

    logic                 shadow_q;
    logic [BLANK_DLY-1:0] lhbl_sr;
    logic [BLANK_DLY-1:0] lvbl_sr;
    chan_t                red, green, blue;
    logic                 dim_en;
    logic                 show;
    rgb15_t               rgb_next;

    // c - c/4, about 75% brightness
    function automatic chan_t dim(input chan_t c);
        return c - (c >> 2);
    endfunction

    // line up shadow with the registered palette read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_q <= 1'b0;
        end else if (pxl_cen) begin
            shadow_q <= shadow;
        end
    end

    // blanking delay line, reset to blanked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[BLANK_DLY-2:0], lhbl};
            lvbl_sr <= {lvbl_sr[BLANK_DLY-2:0], lvbl};
        end
    end

    assign lhbl_dly = lhbl_sr[BLANK_DLY-1];
    assign lvbl_dly = lvbl_sr[BLANK_DLY-1];

    // 4 MSBs from the low 12 bits, LSB from bits 14:12
    assign red   = {pal[3:0],  pal[12]};
    assign green = {pal[7:4],  pal[13]};
    assign blue  = {pal[11:8], pal[14]};

    // bit 15 makes the colour immune to shadow
    assign dim_en = shadow_q & ~pal[15];

    // blanking taps are the values that move to the outputs on this strobe
    assign show = video_en & lhbl_sr[BLANK_DLY-2] & lvbl_sr[BLANK_DLY-2];

    always_comb begin
        if (!show) begin
            rgb_next = '0;
        end else if (dim_en) begin
            rgb_next = {dim(red), dim(green), dim(blue)};
        end else begin
            rgb_next = {red, green, blue};
        end
    end

    // stage 3
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb <= rgb_next;
        end
    end

    // black whenever either blanking output is active
    a_black_in_blank: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!lhbl_dly || !lvbl_dly) |-> (rgb == '0)
    );

endmodule

// File: rtl/video_colmix.sv
/*
  colour mixer top: CPU registers, layer mixer, palette and output stage
  CPU and video share clk, pixels advance on pxl_cen only
  rgb, lhbl_dly and lvbl_dly lag the inputs by BLANK_DLY strobes
*/
`timescale 1ns/1ns

module video_colmix (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    // active low blanking
    input  logic                      lhbl,
    input  logic                      lvbl,
    input  colmix_pkg::layer_pixels_t pixels,
    input  colmix_pkg::cpu_req_t      cpu_req,
    output colmix_pkg::cpu_rsp_t      cpu_rsp,
    output colmix_pkg::rgb15_t        rgb,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);
    import colmix_pkg::*;

    // CPU side of the palette
    logic [1:0] pal_we;
    pal_addr_t  pal_addr;
    pal_word_t  pal_wdata;
    pal_word_t  pal_rdata;
    ctrl_t      ctrl;

    // pixel path
    mix_sel_t   sel;
    pal_word_t  pal_q;

    video_ctrl_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_wdata (pal_wdata),
        .pal_rdata (pal_rdata),
        .ctrl      (ctrl)
    );

    layer_prio_mixer u_mixer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .pixels  (pixels),
        .gfx_en  (ctrl.gfx_en),
        .sel     (sel)
    );

    palette_ram u_pal (
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .we       (pal_we),
        .cpu_addr (pal_addr),
        .wdata    (pal_wdata),
        .cpu_q    (pal_rdata),
        .pix_addr (sel.pal_addr),
        .pix_q    (pal_q)
    );

    // shadow flag goes in undelayed, shade_blank aligns it with pal_q
    shade_blank u_shade (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .shadow   (sel.shadow),
        .pal      (pal_q),
        .video_en (ctrl.video_en),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

// File: verif/tb_video_colmix.sv
/*
  testbench for video_colmix, LCG stimulus with a fixed seed
  the whole palette is written before any pixel is compared
  any CPU write flushes the expected pixel queue
*/
`timescale 1ns/1ns

module tb_video_colmix;
    import colmix_pkg::*;

    // one expected output pixel
    typedef struct packed {
        rgb15_t rgb;
        logic   hb;
        logic   vb;
    } pix_exp_t;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          pxl_cen;
    logic          lhbl;
    logic          lvbl;
    layer_pixels_t pixels;
    cpu_req_t      cpu_req;
    cpu_rsp_t      cpu_rsp;
    rgb15_t        rgb;
    logic          lhbl_dly;
    logic          lvbl_dly;

    // inputs for the next clock
    cpu_req_t      req_next;
    layer_pixels_t px_next;
    logic          hb_next;
    logic          vb_next;

    // reference model state
    pal_word_t     pal_mdl [PAL_DEPTH];
    ctrl_t         ctrl_mdl;
    pix_exp_t      exp_q [$];
    pal_word_t     rsp_exp;
    logic [31:0]   seed = 32'd28742;

    video_colmix UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pixels   (pixels),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    function automatic layer_pixels_t random_pixels();
        logic [47:0] r;
        r = {lcg_next(), lcg_next(), lcg_next()};
        return r[40:0];
    endfunction

    // colour expected for one pixel set, from the slot rules
    function automatic pix_exp_t model_pixel(input layer_pixels_t p, input logic hb,
                                             input logic vb);
        logic [9:0]  tile [4];
        logic [3:0]  tprio;
        logic [9:0]  obj;
        logic [1:0]  oprio;
        logic [10:0] addr;
        logic        shade;
        logic        win;
        logic        spr;
        logic        done;
        pal_word_t   w;
        chan_t       ch [3];
        pix_exp_t    e;
        obj      = p.obj_pxl[9:0];
        oprio    = p.obj_pxl[11:10];
        tile[0]  = {4'd0, p.char_pxl[5:0]};
        tile[1]  = p.scr1_pxl[9:0];
        tile[2]  = p.scr2_pxl[9:0];
        tprio    = {1'b0, p.scr2_pxl[10], p.scr1_pxl[10], p.char_pxl[6]};
        // disabled layer loses its colour index
        for (int l = 0; l < 3; l++) begin
            if (!ctrl_mdl.gfx_en[l]) tile[l][3:0] = 4'd0;
        end
        if (!ctrl_mdl.gfx_en[3]) obj[3:0] = 4'd0;
        // backdrop built from gated scroll 2
        tile[3]  = {tile[2][9:3], 3'd0};
        done     = 1'b0;
        addr     = '0;
        shade    = 1'b0;
        for (int s = 0; s < 4; s++) begin
            // slot s lets the sprite in from priority 3-s upward
            win = obj[3:0] != 4'd0 && int'(oprio) >= 3 - s
                  && (!tprio[s] || tile[s][2:0] == 3'd0);
            spr = win && obj[9:4] != SHADOW_PAL;
            if (!done && (s == 3 || spr || tile[s][2:0] != 3'd0)) begin
                done  = 1'b1;
                addr  = spr ? {1'b1, obj} : {1'b0, tile[s]};
                shade = win && !spr;
            end
        end
        w     = pal_mdl[addr];
        ch[0] = {w[3:0], w[12]};
        ch[1] = {w[7:4], w[13]};
        ch[2] = {w[11:8], w[14]};
        for (int c = 0; c < 3; c++) begin
            if (shade && !w[15]) ch[c] = ch[c] - ch[c] / 4;
        end
        e.rgb = (ctrl_mdl.video_en && hb && vb) ? {ch[0], ch[1], ch[2]} : '0;
        e.hb  = hb;
        e.vb  = vb;
        return e;
    endfunction

    // CPU request as the DUT samples it
    task automatic model_cpu(input cpu_req_t r);
        if (r.wr && !r.sel && r.be[0]) pal_mdl[r.addr][7:0] = r.data[7:0];
        if (r.wr && !r.sel && r.be[1]) pal_mdl[r.addr][15:8] = r.data[15:8];
        if (r.wr && r.sel) ctrl_mdl = r.data[4:0];
        if (r.wr) exp_q.delete();
        if (r.rd) rsp_exp = r.sel ? {11'd0, ctrl_mdl} : pal_mdl[r.addr];
    endtask

    task automatic fail_now();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input rgb15_t exp);
        if (rgb !== exp) begin
            $display("[ERROR] rgb: got %h, expected %h", rgb, exp);
            fail_now();
        end
    endtask

    task automatic check_rsp(input pal_word_t exp);
        if (cpu_rsp.data !== exp) begin
            $display("[ERROR] cpu_rsp.data: got %h, expected %h", cpu_rsp.data, exp);
            fail_now();
        end
    endtask

    task automatic check_blank(input logic hb, input logic vb);
        if ({lhbl_dly, lvbl_dly} !== {hb, vb}) begin
            $display("[ERROR] {lhbl_dly, lvbl_dly}: got %h, expected %h",
                     {lhbl_dly, lvbl_dly}, {hb, vb});
            fail_now();
        end
    endtask

    // one clock: model the sampled inputs, drive the next ones, check at negedge
    task automatic clock_step();
        logic     strobe;
        logic     rd_seen;
        pix_exp_t e;
        @(posedge clk);
        strobe  = pxl_cen;
        rd_seen = cpu_req.rd;
        if (strobe) exp_q.push_back(model_pixel(pixels, lhbl, lvbl));
        model_cpu(cpu_req);
        pxl_cen <= ~pxl_cen;
        pixels  <= px_next;
        lhbl    <= hb_next;
        lvbl    <= vb_next;
        cpu_req <= req_next;
        req_next = '0;
        @(negedge clk);
        // valid only on the clock right after a rd
        if (cpu_rsp.valid !== rd_seen) begin
            $display("[ERROR] cpu_rsp.valid: got %h, expected %h", cpu_rsp.valid, rd_seen);
            fail_now();
        end
        // third strobe of a pixel, its result is on the outputs now
        if (strobe && exp_q.size() == BLANK_DLY) begin
            e = exp_q.pop_front();
            check_rgb(e.rgb);
            check_blank(e.hb, e.vb);
        end
    endtask

    task automatic cpu_write(input logic s, input pal_addr_t a, input logic [15:0] d,
                             input logic [1:0] be);
        req_next      = '0;
        req_next.wr   = 1'b1;
        req_next.sel  = s;
        req_next.addr = a;
        req_next.data = d;
        req_next.be   = be;
        clock_step();
    endtask

    task automatic read_back(input logic s, input pal_addr_t a);
        int   waited;
        logic got;
        req_next      = '0;
        req_next.rd   = 1'b1;
        req_next.sel  = s;
        req_next.addr = a;
        clock_step();
        waited = 0;
        got    = 1'b0;
        while (!got && waited < 4) begin
            clock_step();
            waited++;
            got = cpu_rsp.valid;
        end
        if (!got) begin
            $display("no read response within 4 clocks of rd");
            fail_now();
        end
        if (waited != 1) begin
            $display("read response came %0d clocks after rd, not 1", waited);
            fail_now();
        end
        check_rsp(rsp_exp);
    endtask

    task automatic drive_pixel(input layer_pixels_t px, input logic hb, input logic vb);
        px_next = px;
        hb_next = hb;
        vb_next = vb;
        // pxl_cen is high on one of every two clocks
        repeat (2) clock_step();
    endtask

    initial begin
        logic [15:0]   r;
        pal_addr_t     a;
        layer_pixels_t px;
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        pixels   = '0;
        cpu_req  = '0;
        req_next = '0;
        px_next  = '0;
        hb_next  = 1'b1;
        vb_next  = 1'b1;
        ctrl_mdl = CTRL_RESET;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_rgb('0);
        check_blank(1'b0, 1'b0);
        if (cpu_rsp.valid !== 1'b0) begin
            $display("[ERROR] cpu_rsp.valid: got %h, expected 0", cpu_rsp.valid);
            fail_now();
        end

        // whole palette, full words
        for (int i = 0; i < PAL_DEPTH; i++) begin
            cpu_write(1'b0, i[10:0], lcg_next(), 2'b11);
        end
        // byte lane writes then read-back
        repeat (200) begin
            r = lcg_next();
            a = r[10:0];
            cpu_write(1'b0, a, lcg_next(), r[15:14]);
            read_back(1'b0, a);
        end
        // control register, upper data bits must read as zero
        repeat (20) begin
            cpu_write(1'b1, '0, lcg_next(), 2'b11);
            read_back(1'b1, '0);
        end
        cpu_write(1'b1, '0, 16'h001f, 2'b11);

        // priority mixing, all layers on
        repeat (2000) drive_pixel(random_pixels(), 1'b1, 1'b1);

        // bursts with random layer enables
        repeat (12) begin
            r = lcg_next();
            cpu_write(1'b1, '0, {11'd0, 1'b1, r[3:0]}, 2'b11);
            repeat (100) drive_pixel(random_pixels(), 1'b1, 1'b1);
        end
        cpu_write(1'b1, '0, 16'h001f, 2'b11);

        // shadow sprites at top priority over random tiles
        repeat (300) begin
            px = random_pixels();
            r  = lcg_next();
            px.obj_pxl = {2'd3, SHADOW_PAL, r[3:0] | 4'd1};
            drive_pixel(px, 1'b1, 1'b1);
        end

        // random blanking, mostly visible
        repeat (400) begin
            r = lcg_next();
            drive_pixel(random_pixels(), r[1:0] != 2'd0, r[3:2] != 2'd0);
        end
        // video off, black for everything
        cpu_write(1'b1, '0, 16'h000f, 2'b11);
        repeat (200) drive_pixel(random_pixels(), 1'b1, 1'b1);
        // flush the pixels still in flight
        repeat (8) clock_step();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: video_colmix.f
rtl/colmix_pkg.sv
rtl/video_ctrl_regs.sv
rtl/layer_prio_mixer.sv
rtl/palette_ram.sv
rtl/shade_blank.sv
rtl/video_colmix.sv
verif/tb_video_colmix.sv
